//--- decode_consts.svh
// Instruction format constants for the two-slot decode stage
// Opcode ranges are contiguous; each DEC_OPC_* is the first opcode of its range
`ifndef DECODE_CONSTS_SVH
`define DECODE_CONSTS_SVH

`define DEC_INST_W 32
`define DEC_REG_W 5
`define DEC_OPC_MSB 31
`define DEC_OPC_LSB 27
`define DEC_IMM_BIT 26
`define DEC_DEST_LSB 21
`define DEC_SRC0_LSB 16
`define DEC_SRC1_LSB 11
`define DEC_IMM_W 16

// Opcode range starts above the logic range at 0
`define DEC_OPC_SHIFT 8
`define DEC_OPC_ADDER 12
`define DEC_OPC_MUL 16
`define DEC_OPC_SDIV 18
`define DEC_OPC_UDIV 19
`define DEC_OPC_LDST 20
`define DEC_OPC_BRANCH 24
`define DEC_OPC_INVALID 28

`endif

//--- decode_pkg.sv
// Types shared by the decoder and the decode stage
// exec_unit_t takes four bits for eight units plus none
`include "decode_consts.svh"

package decode_pkg;

	typedef enum logic [3:0] {
		exec_none,
		exec_logic,
		exec_shift,
		exec_adder,
		exec_mul,
		exec_sdiv,
		exec_udiv,
		exec_ldst,
		exec_branch
	} exec_unit_t;

	// One decoded slot of 55 bits
	typedef struct packed {
		logic valid;
		logic [`DEC_OPC_MSB-`DEC_OPC_LSB:0] cmd;
		exec_unit_t exec_unit;
		logic [`DEC_REG_W-1:0] source0;
		logic [`DEC_INST_W-1:0] source1;
		logic source1_imm;
		logic [`DEC_REG_W-1:0] destination;
		logic writeback;
		logic fault_invalid_inst;
	} slot_payload_t;

	// Bundle-wide fetch data of 100 bits
	typedef struct packed {
		logic slot0_pagefault;
		logic slot0_branch_predict;
		logic [`DEC_INST_W-1:0] slot0_branch_predict_addr;
		logic slot1_pagefault;
		logic slot1_branch_predict;
		logic [`DEC_INST_W-1:0] slot1_branch_predict_addr;
		logic [`DEC_INST_W-1:0] pc;
	} system_payload_t;

endpackage

//--- inst_decoder.sv
// Purely combinational decode of one instruction word
// Opcodes 28 to 31 are not defined and raise the invalid-instruction fault
`include "decode_consts.svh"

module inst_decoder (
	input wire [`DEC_INST_W-1:0] inst,
	output logic [`DEC_OPC_MSB-`DEC_OPC_LSB:0] cmd,
	output decode_pkg::exec_unit_t exec_unit,
	output logic [`DEC_REG_W-1:0] source0,
	output logic [`DEC_INST_W-1:0] source1,
	output logic source1_imm,
	output logic [`DEC_REG_W-1:0] destination,
	output logic writeback,
	output logic fault_invalid_inst
);

	logic [`DEC_OPC_MSB-`DEC_OPC_LSB:0] opc;
	logic [`DEC_INST_W-1:0] imm_ext;
	logic [`DEC_INST_W-1:0] reg_ext;

	assign opc = inst[`DEC_OPC_MSB:`DEC_OPC_LSB];

	// Sign-extended immediate and zero-extended register index
	assign imm_ext = {{(`DEC_INST_W-`DEC_IMM_W){inst[`DEC_IMM_W-1]}},
		inst[`DEC_IMM_W-1:0]};
	assign reg_ext = {{(`DEC_INST_W-`DEC_REG_W){1'b0}},
		inst[`DEC_SRC1_LSB +: `DEC_REG_W]};

	always_comb begin
		cmd = opc;
		source0 = inst[`DEC_SRC0_LSB +: `DEC_REG_W];
		destination = inst[`DEC_DEST_LSB +: `DEC_REG_W];
		source1_imm = inst[`DEC_IMM_BIT];
		source1 = source1_imm ? imm_ext : reg_ext;

		// Unit class by opcode range
		if (opc < `DEC_OPC_SHIFT) begin
			exec_unit = decode_pkg::exec_logic;
		end else if (opc < `DEC_OPC_ADDER) begin
			exec_unit = decode_pkg::exec_shift;
		end else if (opc < `DEC_OPC_MUL) begin
			exec_unit = decode_pkg::exec_adder;
		end else if (opc < `DEC_OPC_SDIV) begin
			exec_unit = decode_pkg::exec_mul;
		end else if (opc < `DEC_OPC_UDIV) begin
			exec_unit = decode_pkg::exec_sdiv;
		end else if (opc < `DEC_OPC_LDST) begin
			exec_unit = decode_pkg::exec_udiv;
		end else if (opc < `DEC_OPC_BRANCH) begin
			exec_unit = decode_pkg::exec_ldst;
		end else if (opc < `DEC_OPC_INVALID) begin
			exec_unit = decode_pkg::exec_branch;
		end else begin
			exec_unit = decode_pkg::exec_none;
		end

		fault_invalid_inst = (opc >= `DEC_OPC_INVALID);

		// Stores are the odd load/store opcodes and write no register
		case (exec_unit)
			decode_pkg::exec_none,
			decode_pkg::exec_branch: writeback = 1'b0;
			decode_pkg::exec_ldst: writeback = !opc[0];
			default: writeback = 1'b1;
		endcase

		assert (fault_invalid_inst == (exec_unit == decode_pkg::exec_none))
		else $error("invalid-instruction fault disagrees with unit class");
		assert (!(writeback && fault_invalid_inst))
		else $error("writeback requested on an invalid instruction");
	end

endmodule

//--- stage_register.sv
// One-entry pipeline register with request/busy handshake
// prev_busy depends combinationally on next_busy, so a full stall ripples back
module stage_register #(
	parameter type payload_t = logic
) (
	input wire clock,
	input wire rst_n,
	input wire prev_req,
	output logic prev_busy,
	input payload_t prev_data,
	output logic next_req,
	input wire next_busy,
	output payload_t next_data
);

	logic valid;
	logic accept;
	payload_t data;

	// Busy only while an item is stuck downstream
	assign prev_busy = valid && next_busy;
	assign accept = prev_req && !prev_busy;

	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			valid <= 1'b0;
		end else if (accept) begin
			valid <= 1'b1;
		end else if (!next_busy) begin
			// Item left with nothing behind it
			valid <= 1'b0;
		end
	end

	always_ff @(posedge clock) begin
		if (accept) begin
			data <= prev_data;
		end
	end

	assign next_req = valid;
	assign next_data = data;

	// A stalled item must not move or vanish
	hold_under_busy: assert property (
		@(posedge clock) disable iff (!rst_n)
		next_req && next_busy |=> next_req && $stable(next_data)
	) else $error("stage register lost or changed a stalled item");

	// An accepted item is presented one cycle later
	accept_shows_item: assert property (
		@(posedge clock) disable iff (!rst_n)
		accept |=> next_req && next_data == $past(prev_data)
	) else $error("stage register did not present an accepted item");

endmodule

//--- decode_stage.sv
// Two-slot decode stage, one bundle per cycle, one cycle of latency
// All three registers move together since they share one request and one busy
// Upstream must hold the bundle while prev_lock is high
`include "decode_consts.svh"

module decode_stage (
	input wire clock,
	input wire rst_n,
	input wire prev_valid,
	input wire [`DEC_INST_W-1:0] prev_pc,
	output logic prev_lock,
	input wire prev_0_valid,
	input wire prev_0_pagefault,
	input wire prev_0_branch_predict,
	input wire [`DEC_INST_W-1:0] prev_0_branch_predict_addr,
	input wire [`DEC_INST_W-1:0] prev_0_inst,
	input wire prev_1_valid,
	input wire prev_1_pagefault,
	input wire prev_1_branch_predict,
	input wire [`DEC_INST_W-1:0] prev_1_branch_predict_addr,
	input wire [`DEC_INST_W-1:0] prev_1_inst,
	output logic next_valid,
	output logic [`DEC_INST_W-1:0] next_pc,
	input wire next_lock,
	output logic next_0_valid,
	output logic next_0_fault_pagefault,
	output logic next_0_fault_invalid_inst,
	output logic next_0_branch_predict,
	output logic [`DEC_INST_W-1:0] next_0_branch_predict_addr,
	output logic [`DEC_OPC_MSB-`DEC_OPC_LSB:0] next_0_cmd,
	output decode_pkg::exec_unit_t next_0_exec_unit,
	output logic [`DEC_REG_W-1:0] next_0_source0,
	output logic [`DEC_INST_W-1:0] next_0_source1,
	output logic next_0_source1_imm,
	output logic [`DEC_REG_W-1:0] next_0_destination,
	output logic next_0_writeback,
	output logic next_1_valid,
	output logic next_1_fault_pagefault,
	output logic next_1_fault_invalid_inst,
	output logic next_1_branch_predict,
	output logic [`DEC_INST_W-1:0] next_1_branch_predict_addr,
	output logic [`DEC_OPC_MSB-`DEC_OPC_LSB:0] next_1_cmd,
	output decode_pkg::exec_unit_t next_1_exec_unit,
	output logic [`DEC_REG_W-1:0] next_1_source0,
	output logic [`DEC_INST_W-1:0] next_1_source1,
	output logic next_1_source1_imm,
	output logic [`DEC_REG_W-1:0] next_1_destination,
	output logic next_1_writeback
);

	decode_pkg::slot_payload_t slot0_in;
	decode_pkg::slot_payload_t slot1_in;
	decode_pkg::slot_payload_t slot0_out;
	decode_pkg::slot_payload_t slot1_out;
	decode_pkg::system_payload_t sys_in;
	decode_pkg::system_payload_t sys_out;
	logic sys_busy;
	logic slot0_busy;
	logic slot1_busy;
	logic accept;

	assign slot0_in.valid = prev_0_valid;
	assign slot1_in.valid = prev_1_valid;

	inst_decoder slot0_dec (
		.inst(prev_0_inst),
		.cmd(slot0_in.cmd),
		.exec_unit(slot0_in.exec_unit),
		.source0(slot0_in.source0),
		.source1(slot0_in.source1),
		.source1_imm(slot0_in.source1_imm),
		.destination(slot0_in.destination),
		.writeback(slot0_in.writeback),
		.fault_invalid_inst(slot0_in.fault_invalid_inst)
	);

	inst_decoder slot1_dec (
		.inst(prev_1_inst),
		.cmd(slot1_in.cmd),
		.exec_unit(slot1_in.exec_unit),
		.source0(slot1_in.source0),
		.source1(slot1_in.source1),
		.source1_imm(slot1_in.source1_imm),
		.destination(slot1_in.destination),
		.writeback(slot1_in.writeback),
		.fault_invalid_inst(slot1_in.fault_invalid_inst)
	);

	assign sys_in = '{
		slot0_pagefault: prev_0_pagefault,
		slot0_branch_predict: prev_0_branch_predict,
		slot0_branch_predict_addr: prev_0_branch_predict_addr,
		slot1_pagefault: prev_1_pagefault,
		slot1_branch_predict: prev_1_branch_predict,
		slot1_branch_predict_addr: prev_1_branch_predict_addr,
		pc: prev_pc
	};

	// Bundle is taken only when no register is holding a stalled item
	assign prev_lock = sys_busy || slot0_busy || slot1_busy;
	assign accept = prev_valid && !prev_lock;

	stage_register #(.payload_t(decode_pkg::system_payload_t)) system_reg (
		.clock(clock),
		.rst_n(rst_n),
		.prev_req(accept),
		.prev_busy(sys_busy),
		.prev_data(sys_in),
		.next_req(next_valid),
		.next_busy(next_lock),
		.next_data(sys_out)
	);

	stage_register #(.payload_t(decode_pkg::slot_payload_t)) slot0_reg (
		.clock(clock),
		.rst_n(rst_n),
		.prev_req(accept),
		.prev_busy(slot0_busy),
		.prev_data(slot0_in),
		.next_req(),
		.next_busy(next_lock),
		.next_data(slot0_out)
	);

	stage_register #(.payload_t(decode_pkg::slot_payload_t)) slot1_reg (
		.clock(clock),
		.rst_n(rst_n),
		.prev_req(accept),
		.prev_busy(slot1_busy),
		.prev_data(slot1_in),
		.next_req(),
		.next_busy(next_lock),
		.next_data(slot1_out)
	);

	assign next_pc = sys_out.pc;

	// Per-slot faults come from two registers, fetch fault and decode fault
	assign next_0_valid = slot0_out.valid;
	assign next_0_fault_pagefault = sys_out.slot0_pagefault;
	assign next_0_fault_invalid_inst = slot0_out.fault_invalid_inst;
	assign next_0_branch_predict = sys_out.slot0_branch_predict;
	assign next_0_branch_predict_addr = sys_out.slot0_branch_predict_addr;
	assign next_0_cmd = slot0_out.cmd;
	assign next_0_exec_unit = slot0_out.exec_unit;
	assign next_0_source0 = slot0_out.source0;
	assign next_0_source1 = slot0_out.source1;
	assign next_0_source1_imm = slot0_out.source1_imm;
	assign next_0_destination = slot0_out.destination;
	assign next_0_writeback = slot0_out.writeback;

	assign next_1_valid = slot1_out.valid;
	assign next_1_fault_pagefault = sys_out.slot1_pagefault;
	assign next_1_fault_invalid_inst = slot1_out.fault_invalid_inst;
	assign next_1_branch_predict = sys_out.slot1_branch_predict;
	assign next_1_branch_predict_addr = sys_out.slot1_branch_predict_addr;
	assign next_1_cmd = slot1_out.cmd;
	assign next_1_exec_unit = slot1_out.exec_unit;
	assign next_1_source0 = slot1_out.source0;
	assign next_1_source1 = slot1_out.source1;
	assign next_1_source1_imm = slot1_out.source1_imm;
	assign next_1_destination = slot1_out.destination;
	assign next_1_writeback = slot1_out.writeback;

	// Any slot lock implies the system register also shows a waiting bundle
	lock_has_bundle: assert property (
		@(posedge clock) disable iff (!rst_n)
		prev_lock |-> next_valid && next_lock
	) else $error("upstream locked with no bundle waiting downstream");

endmodule

//--- decode_stage_tb.sv
// Self-checking testbench for the two-slot decode stage
// Stimulus and next_lock come from one LFSR, so a run is fully repeatable
// Each bundle is checked field by field against a reference decode
`include "decode_consts.svh"

module decode_stage_tb;

	localparam int RESET_CYCLES = 8;
	localparam int NUM_DIRECTED = 11;
	localparam int NUM_CALM = 110;
	localparam int NUM_BUNDLES = 260;
	localparam int MAX_CYCLES = 4 * NUM_BUNDLES + RESET_CYCLES;

	logic clock = 1'b0;
	logic rst_n;
	logic prev_valid, prev_lock, next_valid, next_lock;
	logic [31:0] prev_pc, next_pc;
	logic prev_0_valid, prev_0_pagefault, prev_0_branch_predict;
	logic prev_1_valid, prev_1_pagefault, prev_1_branch_predict;
	logic [31:0] prev_0_branch_predict_addr, prev_0_inst;
	logic [31:0] prev_1_branch_predict_addr, prev_1_inst;
	logic next_0_valid, next_0_fault_pagefault, next_0_fault_invalid_inst;
	logic next_0_branch_predict, next_0_source1_imm, next_0_writeback;
	logic [31:0] next_0_branch_predict_addr, next_0_source1;
	logic [4:0] next_0_cmd, next_0_source0, next_0_destination;
	decode_pkg::exec_unit_t next_0_exec_unit;
	logic next_1_valid, next_1_fault_pagefault, next_1_fault_invalid_inst;
	logic next_1_branch_predict, next_1_source1_imm, next_1_writeback;
	logic [31:0] next_1_branch_predict_addr, next_1_source1;
	logic [4:0] next_1_cmd, next_1_source0, next_1_destination;
	decode_pkg::exec_unit_t next_1_exec_unit;

	decode_pkg::system_payload_t exp_sys_q[$];
	decode_pkg::slot_payload_t exp_slot0_q[$];
	decode_pkg::slot_payload_t exp_slot1_q[$];
	decode_pkg::system_payload_t got_sys;
	decode_pkg::slot_payload_t got_slot0, got_slot1;
	logic [31:0] lfsr = 32'ha026;
	logic [31:0] bits;
	logic [31:0] held_pc;
	logic was_held = 1'b0;
	logic accepted_last = 1'b0;
	int sent = 0;
	int accepted_count = 0;
	int taken_count = 0;
	int cycle_count = 0;

	decode_stage UUT (.*);

	always #2 clock = !clock;

	// DUT outputs regrouped so whole bundles compare at once
	assign got_sys = '{next_0_fault_pagefault, next_0_branch_predict,
		next_0_branch_predict_addr, next_1_fault_pagefault, next_1_branch_predict,
		next_1_branch_predict_addr, next_pc};
	assign got_slot0 = '{next_0_valid, next_0_cmd, next_0_exec_unit, next_0_source0,
		next_0_source1, next_0_source1_imm, next_0_destination, next_0_writeback,
		next_0_fault_invalid_inst};
	assign got_slot1 = '{next_1_valid, next_1_cmd, next_1_exec_unit, next_1_source0,
		next_1_source1, next_1_source1_imm, next_1_destination, next_1_writeback,
		next_1_fault_invalid_inst};

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		if (got !== exp) begin
			$display("error at %0t: %s is %h, expected %h", $time, name, got, exp);
			$display("Test FAILED");
			$fatal(1, "value mismatch on %s", name);
		end
	endtask

	task automatic abort_run(input string what);
		$display("%s at %0t", what, $time);
		$display("Test FAILED");
		$fatal(1, "%s", what);
	endtask

	// Galois LFSR with polynomial x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
	endfunction

	task automatic take_bits(input int n, output logic [31:0] value);
		value = 32'h0;
		for (int i = 0; i < n; i++) begin
			value = {value[30:0], lfsr[0]};
			lfsr = lfsr_step(lfsr);
		end
	endtask

	// One opcode from every class, with both a load and a store
	function automatic logic [4:0] directed_opcode(input int idx);
		case (idx)
			0: return 5'd0;
			1: return 5'd8;
			2: return 5'd12;
			3: return 5'd16;
			4: return 5'd18;
			5: return 5'd19;
			6: return 5'd20;
			7: return 5'd21;
			8: return 5'd24;
			9: return 5'd28;
			default: return 5'd31;
		endcase
	endfunction

	function automatic decode_pkg::slot_payload_t expect_decode(input logic [31:0] inst,
		input logic valid);
		decode_pkg::slot_payload_t d;
		logic [4:0] opc;
		logic is_store;
		opc = inst[`DEC_OPC_MSB:`DEC_OPC_LSB];
		d.valid = valid;
		d.cmd = opc;
		d.source0 = inst[`DEC_SRC0_LSB +: `DEC_REG_W];
		d.destination = inst[`DEC_DEST_LSB +: `DEC_REG_W];
		d.source1_imm = inst[`DEC_IMM_BIT];
		if (d.source1_imm) begin
			d.source1 = {{16{inst[15]}}, inst[15:0]};
		end else begin
			d.source1 = {27'h0, inst[`DEC_SRC1_LSB +: `DEC_REG_W]};
		end
		if (opc >= 5'(`DEC_OPC_INVALID)) d.exec_unit = decode_pkg::exec_none;
		else if (opc >= 5'(`DEC_OPC_BRANCH)) d.exec_unit = decode_pkg::exec_branch;
		else if (opc >= 5'(`DEC_OPC_LDST)) d.exec_unit = decode_pkg::exec_ldst;
		else if (opc == 5'(`DEC_OPC_UDIV)) d.exec_unit = decode_pkg::exec_udiv;
		else if (opc == 5'(`DEC_OPC_SDIV)) d.exec_unit = decode_pkg::exec_sdiv;
		else if (opc >= 5'(`DEC_OPC_MUL)) d.exec_unit = decode_pkg::exec_mul;
		else if (opc >= 5'(`DEC_OPC_ADDER)) d.exec_unit = decode_pkg::exec_adder;
		else if (opc >= 5'(`DEC_OPC_SHIFT)) d.exec_unit = decode_pkg::exec_shift;
		else d.exec_unit = decode_pkg::exec_logic;
		is_store = (d.exec_unit == decode_pkg::exec_ldst) && opc[0];
		d.fault_invalid_inst = (opc >= 5'(`DEC_OPC_INVALID));
		d.writeback = !d.fault_invalid_inst && !is_store
			&& (d.exec_unit != decode_pkg::exec_branch);
		return d;
	endfunction

	task automatic compare_slot(input string prefix, input decode_pkg::slot_payload_t got,
		input decode_pkg::slot_payload_t exp);
		check_value({prefix, "_valid"}, 32'(got.valid), 32'(exp.valid));
		check_value({prefix, "_cmd"}, 32'(got.cmd), 32'(exp.cmd));
		check_value({prefix, "_exec_unit"}, 32'(got.exec_unit), 32'(exp.exec_unit));
		check_value({prefix, "_source0"}, 32'(got.source0), 32'(exp.source0));
		check_value({prefix, "_source1"}, got.source1, exp.source1);
		check_value({prefix, "_source1_imm"}, 32'(got.source1_imm), 32'(exp.source1_imm));
		check_value({prefix, "_destination"}, 32'(got.destination), 32'(exp.destination));
		check_value({prefix, "_writeback"}, 32'(got.writeback), 32'(exp.writeback));
		check_value({prefix, "_fault_invalid_inst"}, 32'(got.fault_invalid_inst),
			32'(exp.fault_invalid_inst));
	endtask

	task automatic compare_system(input decode_pkg::system_payload_t got,
		input decode_pkg::system_payload_t exp);
		check_value("next_pc", got.pc, exp.pc);
		check_value("next_0_fault_pagefault", 32'(got.slot0_pagefault), 32'(exp.slot0_pagefault));
		check_value("next_0_branch_predict", 32'(got.slot0_branch_predict),
			32'(exp.slot0_branch_predict));
		check_value("next_0_branch_predict_addr", got.slot0_branch_predict_addr,
			exp.slot0_branch_predict_addr);
		check_value("next_1_fault_pagefault", 32'(got.slot1_pagefault), 32'(exp.slot1_pagefault));
		check_value("next_1_branch_predict", 32'(got.slot1_branch_predict),
			32'(exp.slot1_branch_predict));
		check_value("next_1_branch_predict_addr", got.slot1_branch_predict_addr,
			exp.slot1_branch_predict_addr);
	endtask

	task automatic drive_bundle(input int idx);
		take_bits(32, bits);
		prev_pc = bits;
		take_bits(32, prev_0_branch_predict_addr);
		take_bits(32, prev_1_branch_predict_addr);
		take_bits(32, prev_0_inst);
		take_bits(32, prev_1_inst);
		if (idx < NUM_DIRECTED) begin
			prev_0_inst[31:27] = directed_opcode(idx);
			prev_1_inst[31:27] = directed_opcode(NUM_DIRECTED - 1 - idx);
		end
		take_bits(6, bits);
		{prev_0_valid, prev_0_pagefault, prev_0_branch_predict} = bits[2:0];
		{prev_1_valid, prev_1_pagefault, prev_1_branch_predict} = bits[5:3];
		prev_valid = 1'b1;
	endtask

	// Scoreboard and protocol checks on values from before the edge
	always @(posedge clock) begin
		if (rst_n) begin
			// The queue holds exactly the bundle sitting in the stage
			check_value("next_valid", 32'(next_valid), 32'(exp_sys_q.size() != 0));
			check_value("prev_lock", 32'(prev_lock),
				32'(exp_sys_q.size() != 0 && next_lock));
			if (accepted_last) begin
				check_value("next_valid", 32'(next_valid), 32'h1);
				check_value("bundles in flight", 32'(exp_sys_q.size()), 32'h1);
			end
			if (was_held) begin
				check_value("next_valid", 32'(next_valid), 32'h1);
				check_value("next_pc", next_pc, held_pc);
			end
			if (next_valid && !next_lock) begin
				if (exp_sys_q.size() == 0) begin
					abort_run("DUT delivered a bundle that was never accepted");
				end
				compare_system(got_sys, exp_sys_q.pop_front());
				compare_slot("next_0", got_slot0, exp_slot0_q.pop_front());
				compare_slot("next_1", got_slot1, exp_slot1_q.pop_front());
				taken_count++;
			end
			accepted_last = prev_valid && !prev_lock;
			if (accepted_last) begin
				exp_sys_q.push_back('{prev_0_pagefault, prev_0_branch_predict,
					prev_0_branch_predict_addr, prev_1_pagefault, prev_1_branch_predict,
					prev_1_branch_predict_addr, prev_pc});
				exp_slot0_q.push_back(expect_decode(prev_0_inst, prev_0_valid));
				exp_slot1_q.push_back(expect_decode(prev_1_inst, prev_1_valid));
				accepted_count++;
			end
			was_held = next_valid && next_lock;
			held_pc = next_pc;
		end
	end

	always @(posedge clock) begin
		cycle_count++;
		if (cycle_count > MAX_CYCLES) begin
			abort_run("Timeout: not all bundles came out of the decode stage");
		end
	end

	initial begin
		rst_n = 1'b0;
		next_lock = 1'b0;
		prev_valid = 1'b0;
		prev_pc = 32'h0;
		{prev_0_valid, prev_0_pagefault, prev_0_branch_predict} = 3'b000;
		{prev_1_valid, prev_1_pagefault, prev_1_branch_predict} = 3'b000;
		prev_0_branch_predict_addr = 32'h0;
		prev_1_branch_predict_addr = 32'h0;
		prev_0_inst = 32'h0;
		prev_1_inst = 32'h0;
		repeat (RESET_CYCLES) @(posedge clock);
		@(negedge clock);
		rst_n = 1'b1;
		check_value("next_valid", 32'(next_valid), 32'h0);
		check_value("prev_lock", 32'(prev_lock), 32'h0);

		// Back-pressure starts once the directed and calm bundles are out
		while (taken_count < NUM_BUNDLES) begin
			@(negedge clock);
			if (sent > NUM_CALM) begin
				take_bits(1, bits);
				next_lock = bits[0];
			end else begin
				next_lock = 1'b0;
			end
			if (accepted_count == sent) begin
				if (sent < NUM_BUNDLES) begin
					drive_bundle(sent);
					sent++;
				end else begin
					prev_valid = 1'b0;
				end
			end
		end
		next_lock = 1'b0;
		check_value("next_valid", 32'(next_valid), 32'h0);

		if (exp_sys_q.size() == 0 && accepted_count == NUM_BUNDLES) begin
			$display("Test OK");
			$finish;
		end else begin
			$display("Bundles left over in the scoreboard");
			$display("Test FAILED");
			$fatal(1, "scoreboard not empty");
		end
	end

endmodule

//--- verilog.f
+incdir+.
decode_pkg.sv
inst_decoder.sv
stage_register.sv
decode_stage.sv
decode_stage_tb.sv

//--- Makefile
SRCS = decode_consts.svh decode_pkg.sv inst_decoder.sv stage_register.sv \
	decode_stage.sv decode_stage_tb.sv

all: run

obj_dir/Vdecode_stage_tb: $(SRCS) verilog.f
	verilator --binary --timing --assert -f verilog.f \
		--top-module decode_stage_tb -o Vdecode_stage_tb

run: obj_dir/Vdecode_stage_tb
	./obj_dir/Vdecode_stage_tb > sim.log 2>&1 || true
	cat sim.log
	grep -q "^Test OK$$" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: all run clean
